//--- files.f
+incdir+verilog
verilog/tcdm_pkg.sv
verilog/sideband_pkg.sv
verilog/efpga_req_gate.sv
verilog/tcdm_port_buffer.sv
verilog/l2_port_arbiter.sv
verilog/control_event_sync.sv
verilog/efpga_tcdm_bridge.sv
testbench/efpga_bridge_properties.sv
testbench/tb_efpga_tcdm_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_efpga_tcdm_bridge -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_efpga_tcdm_bridge 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF "All tests passed!"; then
  exit 0
else
  exit 1
fi

//--- testbench/tb_efpga_tcdm_bridge.sv
// testbench for the efpga tcdm bridge
// random fabric traffic, l2 memory model, credit and response model, sideband tests
`timescale 1ns/1ns
`include "efpga_macros.svh"

module tb_efpga_tcdm_bridge
  import tcdm_pkg::*;
  import sideband_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_TXN      = 200;          // transactions per traffic phase
  localparam int TOTAL_TXN  = 4 * N_TXN;
  localparam int WDOG_CYCLES = TOTAL_TXN * 64 + 1000;
  localparam logic [31:0] LFSR_SEED = 32'hb8ce;

  logic                          asic_clk_i;
  logic                          rst_n;
  port_mask_t                    port_en;
  port_mask_t                    fab_req_valid;
  fab_req_t [`EFPGA_N_PORTS-1:0] fab_req;
  port_mask_t                    fab_credit;
  port_mask_t                    fab_rsp_valid;
  data_t                         fab_rdata;
  logic                          l2_req;
  l2_req_t                       l2_req_data;
  logic                          l2_gnt;
  logic                          l2_rvalid;
  data_t                         l2_rdata;
  ctrl_word_t                    control;
  ctrl_word_t                    control_out;
  logic                          events_en;
  event_vec_t                    event_lvl;
  event_vec_t                    event_out;

  logic [31:0] stim_lfsr;
  logic [31:0] l2_lfsr;
  string       test_name;
  int          cycle;
  int          last_due;
  logic        stall;                       // heavy back-pressure on the l2 side
  int          credits [`EFPGA_N_PORTS];
  l2_req_t     exp_l2_q [`EFPGA_N_PORTS][$];
  data_t       exp_rsp_q [`EFPGA_N_PORTS][$];
  data_t       exp_mem [l2_addr_t];         // fabric view of memory
  data_t       l2_mem [l2_addr_t];          // slave memory, written from the bus
  data_t       rsp_data_q [$];
  int          rsp_due_q [$];
  ctrl_word_t  ctrl_smp;
  event_vec_t  event_smp;

  efpga_tcdm_bridge efpga_tcdm_bridge_i (
    .asic_clk_i      (asic_clk_i),
    .rst_n           (rst_n),
    .port_en_i       (port_en),
    .fab_req_valid_i (fab_req_valid),
    .fab_req_i       (fab_req),
    .fab_credit_o    (fab_credit),
    .fab_rsp_valid_o (fab_rsp_valid),
    .fab_rdata_o     (fab_rdata),
    .l2_req_o        (l2_req),
    .l2_req_data_o   (l2_req_data),
    .l2_gnt_i        (l2_gnt),
    .l2_rvalid_i     (l2_rvalid),
    .l2_rdata_i      (l2_rdata),
    .control_i       (control),
    .control_o       (control_out),
    .events_en_i     (events_en),
    .event_i         (event_lvl),
    .event_o         (event_out)
  );

  initial begin
    asic_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) asic_clk_i = ~asic_clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v  = {v[30:0], st[0]};
      st = lfsr_next(st);
    end
  endtask

  function automatic data_t fill_word(input l2_addr_t a);
    fill_word = (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};  // unwritten memory content
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t nw, input be_t be);
    merge_bytes = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merge_bytes[b*8 +: 8] = nw[b*8 +: 8];
    end
  endfunction

  task automatic report_failure(input string why);
    $display("%s (test %s)", why, test_name);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [95:0] expected,
                             input logic [95:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
    end
  endtask

  // runs at the falling edge, outputs are stable here
  task automatic observe_outputs();
    logic [31:0] bits;
    port_idx_t   pi;
    l2_req_t     exp_req;
    data_t       cur;
    int          due;
    cycle++;
    ctrl_smp  = control_out;
    event_smp = event_out;
    for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
      if (fab_credit[p]) credits[p]++;
      if (credits[p] > `EFPGA_BUF_DEPTH) report_failure("more credits returned than issued");
      if (fab_rsp_valid[p]) begin
        if (exp_rsp_q[p].size() == 0) report_failure("read response on a port with none pending");
        check_value("read data", 96'(exp_rsp_q[p].pop_front()), 96'(fab_rdata));
      end
    end
    if (l2_req && l2_gnt) begin
      pi = l2_req_data.addr[19:18];                      // port is encoded in the offset
      check_value("l2 base", 96'(`EFPGA_L2_BASE), 96'(l2_req_data.addr[31:20]));
      if (exp_l2_q[pi].size() == 0) report_failure("l2 request without a matching fabric request");
      exp_req = exp_l2_q[pi].pop_front();
      check_value("l2 request", 96'(exp_req), 96'(l2_req_data));
      cur = l2_mem.exists(l2_req_data.addr) ? l2_mem[l2_req_data.addr] : fill_word(l2_req_data.addr);
      if (!l2_req_data.wen) begin
        l2_mem[l2_req_data.addr] = merge_bytes(cur, l2_req_data.wdata, l2_req_data.be);
        cur = '0;
      end
      take_bits(l2_lfsr, stall ? 4 : 2, bits);
      due = cycle + int'(bits[3:0]);
      if (due < last_due) due = last_due;              // keep responses in order
      last_due = due;
      rsp_data_q.push_back(cur);
      rsp_due_q.push_back(due);
    end
  endtask

  task automatic drive_l2_slave();
    logic [31:0] bits;
    take_bits(l2_lfsr, 2, bits);
    l2_gnt = stall ? (bits[1:0] == 2'b00) : (bits[1:0] != 2'b00);
    if (rsp_data_q.size() != 0 && rsp_due_q[0] <= cycle) begin
      l2_rvalid = 1'b1;
      l2_rdata  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      l2_rvalid = 1'b0;
    end
  endtask

  // returns at 2 ns after the rising edge, ready for new inputs
  task automatic step_cycle();
    @(negedge asic_clk_i);
    observe_outputs();
    @(posedge asic_clk_i);
    #2;
    drive_l2_slave();
  endtask

  // mode 0 writes, 1 reads, 2 mixed
  task automatic issue_traffic(input int n_txn, input int mode);
    logic [31:0] bits;
    logic        rd;
    addr_off_t   off;
    l2_addr_t    addr;
    data_t       cur;
    int          issued;
    issued = 0;
    while (issued < n_txn) begin
      step_cycle();
      fab_req_valid = '0;
      for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
        take_bits(stim_lfsr, 1, bits);
        if (bits[0] && credits[p] > 0 && issued < n_txn) begin
          take_bits(stim_lfsr, 32, bits);
          fab_req[p].wdata = bits;
          take_bits(stim_lfsr, 9, bits);
          rd  = (mode == 2) ? bits[8] : (mode == 1);
          off = {port_idx_t'(p), 12'h000, bits[7:4], 2'b00};
          fab_req[p].wen    = rd;
          fab_req[p].offset = off;
          fab_req[p].be     = bits[3:0];
          fab_req_valid[p]  = 1'b1;
          credits[p]--;
          issued++;
          if (port_en[p]) begin
            addr = {`EFPGA_L2_BASE, off};
            exp_l2_q[p].push_back('{wen: rd, addr: addr, be: bits[3:0], wdata: fab_req[p].wdata});
            cur = exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
            if (rd) exp_rsp_q[p].push_back(cur);
            else exp_mem[addr] = merge_bytes(cur, fab_req[p].wdata, bits[3:0]);
          end
        end
      end
    end
    step_cycle();
    fab_req_valid = '0;
  endtask

  function automatic logic traffic_idle();
    for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
      if (exp_l2_q[p].size() != 0 || exp_rsp_q[p].size() != 0) return 1'b0;
    end
    return rsp_data_q.size() == 0;
  endfunction

  task automatic wait_idle();
    while (!traffic_idle()) step_cycle();
    repeat (8) step_cycle();                             // late credit and write responses
  endtask

  task automatic check_credits();
    for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
      check_value("credits returned", 96'(`EFPGA_BUF_DEPTH), 96'(credits[p]));
    end
  endtask

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before the tests completed");
  end

  initial begin
    logic [31:0] bits;
    ctrl_word_t  word;
    event_vec_t  exp_ev;
    rst_n = 1'b0;
    port_en = '1;
    fab_req_valid = '0;
    fab_req = '0;
    l2_gnt = 1'b0;
    l2_rvalid = 1'b0;
    l2_rdata = '0;
    control = '0;
    events_en = 1'b0;
    event_lvl = '0;
    stim_lfsr = LFSR_SEED;
    l2_lfsr = lfsr_next(LFSR_SEED);
    stall = 1'b0;
    cycle = 0;
    last_due = 0;
    for (int p = 0; p < `EFPGA_N_PORTS; p++) credits[p] = `EFPGA_BUF_DEPTH;
    repeat (5) @(posedge asic_clk_i);
    #2;
    rst_n = 1'b1;

    test_name = "reset";
    step_cycle();
    check_value("control after reset", 96'(0), 96'(ctrl_smp));
    check_value("events after reset", 96'(0), 96'(event_smp));
    check_value("credit pulses after reset", 96'(0), 96'(fab_credit));
    check_value("l2 request after reset", 96'(0), 96'(l2_req));

    test_name = "write then read";
    issue_traffic(N_TXN, 0);
    wait_idle();
    issue_traffic(N_TXN, 1);
    wait_idle();

    test_name = "credits";
    check_credits();

    test_name = "disabled ports";
    port_en = 4'b0101;                                   // ports 1 and 3 dropped
    issue_traffic(N_TXN, 2);
    wait_idle();
    check_credits();
    port_en = '1;

    test_name = "back-pressure";
    stall = 1'b1;
    issue_traffic(N_TXN, 2);
    wait_idle();
    check_credits();
    stall = 1'b0;

    test_name = "control filter";
    for (int k = 0; k < 4; k++) begin
      take_bits(stim_lfsr, 32, bits);
      word = bits;
      control = word;
      repeat (8) step_cycle();
      check_value("held word", 96'(word), 96'(ctrl_smp));
      take_bits(stim_lfsr, 32, bits);
      control = bits;                                    // single-cycle glitch
      step_cycle();
      control = word;
      repeat (8) begin
        step_cycle();
        check_value("glitch filtered", 96'(word), 96'(ctrl_smp));
      end
    end

    test_name = "events";
    for (int k = 0; k < 8; k++) begin
      take_bits(stim_lfsr, 5, bits);
      events_en = (k < 5);
      event_lvl = '0;
      repeat (4) step_cycle();
      event_lvl = event_vec_t'(1) << bits[3:0];
      for (int j = 1; j <= 6; j++) begin
        step_cycle();
        exp_ev = (j == 4 && events_en) ? event_lvl : '0;
        check_value("event pulse", 96'(exp_ev), 96'(event_smp));
      end
      event_lvl = '0;
    end
    repeat (4) step_cycle();

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- testbench/efpga_bridge_properties.sv
// concurrent checks on fabric credits and the l2 request handshake
// bound into the bridge top level
`timescale 1ns/1ns
`include "efpga_macros.svh"

module efpga_bridge_properties
  import tcdm_pkg::*;
  import sideband_pkg::*;
(
  input logic       asic_clk_i,
  input logic       rst_n,
  input port_mask_t fab_req_valid_i,
  input port_mask_t fab_credit_o,
  input port_mask_t fab_rsp_valid_o,
  input logic       l2_req_o,
  input l2_req_t    l2_req_data_o,
  input logic       l2_gnt_i
);

  int credit_cnt [`EFPGA_N_PORTS];  // credits held by the fabric

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < `EFPGA_N_PORTS; p++) credit_cnt[p] <= `EFPGA_BUF_DEPTH;
    end else begin
      for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
        credit_cnt[p] <= credit_cnt[p] + int'(fab_credit_o[p]) - int'(fab_req_valid_i[p]);
      end
    end
  end

  a_req_held: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    l2_req_o && !l2_gnt_i |=> l2_req_o && $stable(l2_req_data_o))
    else $error("l2 request dropped or changed before grant");

  a_quiet_after_reset: assert property (@(posedge asic_clk_i)
    $rose(rst_n) |-> (fab_credit_o == '0) && (fab_rsp_valid_o == '0))
    else $error("credit or response pulse right after reset");

  for (genvar p = 0; p < `EFPGA_N_PORTS; p++) begin : g_credit
    a_credit_range: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (credit_cnt[p] >= 0) && (credit_cnt[p] <= `EFPGA_BUF_DEPTH))
      else $error("fabric credit count out of range");
  end

endmodule

bind efpga_tcdm_bridge efpga_bridge_properties bridge_props_i (
  .asic_clk_i      (asic_clk_i),
  .rst_n           (rst_n),
  .fab_req_valid_i (fab_req_valid_i),
  .fab_credit_o    (fab_credit_o),
  .fab_rsp_valid_o (fab_rsp_valid_o),
  .l2_req_o        (l2_req_o),
  .l2_req_data_o   (l2_req_data_o),
  .l2_gnt_i        (l2_gnt_i)
);

//--- verilog/efpga_tcdm_bridge.sv
// top level of the efpga to l2 bridge
// request gate, port buffers, l2 arbiter and sideband sync
`timescale 1ns/1ns
`include "efpga_macros.svh"

module efpga_tcdm_bridge
  import tcdm_pkg::*;
  import sideband_pkg::*;
(
  input  logic                          asic_clk_i,
  input  logic                          rst_n,
  input  port_mask_t                    port_en_i,
  input  port_mask_t                    fab_req_valid_i,
  input  fab_req_t [`EFPGA_N_PORTS-1:0] fab_req_i,
  output port_mask_t                    fab_credit_o,
  output port_mask_t                    fab_rsp_valid_o,
  output data_t                         fab_rdata_o,
  output logic                          l2_req_o,
  output l2_req_t                       l2_req_data_o,
  input  logic                          l2_gnt_i,
  input  logic                          l2_rvalid_i,
  input  data_t                         l2_rdata_i,
  input  ctrl_word_t                    control_i,
  output ctrl_word_t                    control_o,
  input  logic                          events_en_i,
  input  event_vec_t                    event_i,
  output event_vec_t                    event_o
);

  port_mask_t                    buf_valid;
  l2_req_t  [`EFPGA_N_PORTS-1:0] buf_req;
  port_mask_t                    buf_pop;
  wire port_mask_t               buf_credit;     // one bit per buffer instance
  wire port_mask_t               buf_not_empty;
  wire l2_req_t [`EFPGA_N_PORTS-1:0] buf_head;

  efpga_req_gate req_gate_i (
    .asic_clk_i   (asic_clk_i),
    .rst_n        (rst_n),
    .port_en_i    (port_en_i),
    .fab_valid_i  (fab_req_valid_i),
    .fab_req_i    (fab_req_i),
    .buf_valid_o  (buf_valid),
    .buf_req_o    (buf_req),
    .buf_credit_i (buf_credit),
    .fab_credit_o (fab_credit_o)
  );

  for (genvar p = 0; p < `EFPGA_N_PORTS; p++) begin : g_port_buf
    tcdm_port_buffer port_buffer_i (
      .asic_clk_i  (asic_clk_i),
      .rst_n       (rst_n),
      .push_i      (buf_valid[p]),
      .push_req_i  (buf_req[p]),
      .pop_i       (buf_pop[p]),
      .not_empty_o (buf_not_empty[p]),
      .head_o      (buf_head[p]),
      .credit_o    (buf_credit[p])
    );
  end

  l2_port_arbiter l2_arbiter_i (
    .asic_clk_i    (asic_clk_i),
    .rst_n         (rst_n),
    .not_empty_i   (buf_not_empty),
    .head_i        (buf_head),
    .pop_o         (buf_pop),
    .l2_req_o      (l2_req_o),
    .l2_req_data_o (l2_req_data_o),
    .l2_gnt_i      (l2_gnt_i),
    .l2_rvalid_i   (l2_rvalid_i),
    .l2_rdata_i    (l2_rdata_i),
    .rsp_valid_o   (fab_rsp_valid_o),
    .rsp_rdata_o   (fab_rdata_o)
  );

  control_event_sync sideband_sync_i (
    .asic_clk_i  (asic_clk_i),
    .rst_n       (rst_n),
    .control_i   (control_i),
    .control_o   (control_o),
    .events_en_i (events_en_i),
    .event_i     (event_i),
    .event_o     (event_o)
  );

endmodule

//--- verilog/control_event_sync.sv
// stability filter for the control word
// event gating and rising edge pulses
`timescale 1ns/1ns
`include "efpga_macros.svh"

module control_event_sync
  import sideband_pkg::*;
(
  input  logic       asic_clk_i,
  input  logic       rst_n,
  input  ctrl_word_t control_i,
  output ctrl_word_t control_o,
  input  logic       events_en_i,
  input  event_vec_t event_i,
  output event_vec_t event_o
);

  ctrl_word_t ctrl_d1_q;
  ctrl_word_t ctrl_d2_q;
  logic       ctrl_stable_q;   // three equal samples seen
  event_vec_t event_gated;
  event_vec_t ev_s1_q;
  event_vec_t ev_s2_q;
  event_vec_t ev_prev_q;

  assign event_gated = event_i & {`EFPGA_N_EVENTS{events_en_i}};

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_d1_q     <= '0;
      ctrl_d2_q     <= '0;
      ctrl_stable_q <= 1'b0;
      control_o     <= '0;
    end else begin
      ctrl_d1_q     <= control_i;
      ctrl_d2_q     <= ctrl_d1_q;
      ctrl_stable_q <= (ctrl_d1_q == control_i) && (ctrl_d2_q == control_i);
      if (ctrl_stable_q) control_o <= ctrl_d1_q;  // d1 still holds the filtered value
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ev_s1_q   <= '0;
      ev_s2_q   <= '0;
      ev_prev_q <= '0;
      event_o   <= '0;
    end else begin
      ev_s1_q   <= event_gated;
      ev_s2_q   <= ev_s1_q;
      ev_prev_q <= ev_s2_q;
      event_o   <= ev_s2_q & ~ev_prev_q;  // rising edge only
    end
  end

endmodule

//--- verilog/l2_port_arbiter.sv
// round-robin merge of the port buffers onto one l2 master
// tag FIFO routes read data back to the issuing port
`timescale 1ns/1ns
`include "efpga_macros.svh"

module l2_port_arbiter
  import tcdm_pkg::*;
  import sideband_pkg::*;
(
  input  logic                          asic_clk_i,
  input  logic                          rst_n,
  input  port_mask_t                    not_empty_i,
  input  l2_req_t  [`EFPGA_N_PORTS-1:0] head_i,
  output port_mask_t                    pop_o,
  output logic                          l2_req_o,
  output l2_req_t                       l2_req_data_o,
  input  logic                          l2_gnt_i,
  input  logic                          l2_rvalid_i,
  input  data_t                         l2_rdata_i,
  output port_mask_t                    rsp_valid_o,
  output data_t                         rsp_rdata_o
);

  localparam int TPTR_W = $clog2(`EFPGA_TAG_DEPTH);
  localparam int TCNT_W = $clog2(`EFPGA_TAG_DEPTH + 1);

  // what a response needs to find its way back
  typedef struct packed {
    port_idx_t port;
    logic      wen;
  } tag_t;

  port_idx_t         rr_q;         // last port served
  port_idx_t         sel;
  port_idx_t         cand;
  logic              any;
  logic              req_valid_q;
  l2_req_t           req_q;
  port_idx_t         req_port_q;
  logic              hs;
  logic              slot_free;
  logic              room;
  logic              load;
  tag_t              tag_mem_q [`EFPGA_TAG_DEPTH];
  tag_t              tag_head;
  logic [TPTR_W-1:0] tag_wr_q;
  logic [TPTR_W-1:0] tag_rd_q;
  logic [TCNT_W-1:0] tag_cnt_q;

  // first non-empty port after the last one served
  always_comb begin
    sel  = rr_q;
    cand = rr_q;
    any  = 1'b0;
    for (int i = 1; i <= `EFPGA_N_PORTS; i++) begin
      cand = port_idx_t'((int'(rr_q) + i) % `EFPGA_N_PORTS);
      if (!any && not_empty_i[cand]) begin
        sel = cand;
        any = 1'b1;
      end
    end
  end

  assign hs        = req_valid_q & l2_gnt_i;
  assign slot_free = ~req_valid_q | hs;
  // a tag slot must exist for the held request and the new one
  assign room      = (tag_cnt_q + TCNT_W'(req_valid_q)) < TCNT_W'(`EFPGA_TAG_DEPTH);
  assign load      = any & slot_free & room;

  always_comb begin
    pop_o = '0;
    if (load) pop_o[sel] = 1'b1;
  end

  assign l2_req_o      = req_valid_q;
  assign l2_req_data_o = req_q;
  assign tag_head      = tag_mem_q[tag_rd_q];

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
      rr_q        <= '0;
    end else if (load) begin
      req_valid_q <= 1'b1;
      rr_q        <= sel;
    end else if (hs) begin
      req_valid_q <= 1'b0;
    end
  end

  // output register held until grant
  always_ff @(posedge asic_clk_i) begin
    if (load) begin
      req_q      <= head_i[sel];
      req_port_q <= sel;
    end
    if (hs) tag_mem_q[tag_wr_q] <= '{port: req_port_q, wen: req_q.wen};
    if (l2_rvalid_i) rsp_rdata_o <= l2_rdata_i;
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      tag_wr_q    <= '0;
      tag_rd_q    <= '0;
      tag_cnt_q   <= '0;
      rsp_valid_o <= '0;
    end else begin
      if (hs) tag_wr_q <= tag_wr_q + 1'b1;
      if (l2_rvalid_i) tag_rd_q <= tag_rd_q + 1'b1;  // responses come back in order
      tag_cnt_q   <= tag_cnt_q + TCNT_W'(hs) - TCNT_W'(l2_rvalid_i);
      rsp_valid_o <= '0;
      if (l2_rvalid_i && tag_head.wen) rsp_valid_o[tag_head.port] <= 1'b1;  // reads only
    end
  end

endmodule

//--- verilog/tcdm_port_buffer.sv
// request FIFO of one fabric port
// returns a credit pulse for every released entry
`timescale 1ns/1ns
`include "efpga_macros.svh"

module tcdm_port_buffer
  import tcdm_pkg::*;
(
  input  logic    asic_clk_i,
  input  logic    rst_n,
  input  logic    push_i,
  input  l2_req_t push_req_i,
  input  logic    pop_i,
  output logic    not_empty_o,
  output l2_req_t head_o,
  output logic    credit_o
);

  localparam int PTR_W = $clog2(`EFPGA_BUF_DEPTH);
  localparam int CNT_W = $clog2(`EFPGA_BUF_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  l2_req_t mem_q [`EFPGA_BUF_DEPTH];
  ptr_t    wr_ptr_q;
  ptr_t    rd_ptr_q;
  cnt_t    count_q;
  logic    do_pop;

  assign not_empty_o = count_q != '0;
  assign head_o      = mem_q[rd_ptr_q];
  assign do_pop      = pop_i & not_empty_o;  // ignore pop on empty

  // no overflow check, the credit loop bounds the fill level
  always_ff @(posedge asic_clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_req_i;
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q  <= count_q + cnt_t'(push_i) - cnt_t'(do_pop);
      credit_o <= do_pop;  // one credit per released entry
    end
  end

endmodule

//--- verilog/efpga_req_gate.sv
// fabric request intake with per-port enable
// builds l2 addresses and merges credit returns
`timescale 1ns/1ns
`include "efpga_macros.svh"

module efpga_req_gate
  import tcdm_pkg::*;
  import sideband_pkg::*;
(
  input  logic                          asic_clk_i,
  input  logic                          rst_n,
  input  port_mask_t                    port_en_i,
  input  port_mask_t                    fab_valid_i,
  input  fab_req_t [`EFPGA_N_PORTS-1:0] fab_req_i,
  output port_mask_t                    buf_valid_o,
  output l2_req_t  [`EFPGA_N_PORTS-1:0] buf_req_o,
  input  port_mask_t                    buf_credit_i,
  output port_mask_t                    fab_credit_o
);

  localparam int OWED_W = $clog2(`EFPGA_BUF_DEPTH + 1);

  typedef logic [OWED_W-1:0] owed_cnt_t;

  port_mask_t drop;                          // request on a disabled port
  port_mask_t owed_nz;                       // drop credit waiting
  port_mask_t owed_out;                      // drop credit sent this cycle
  owed_cnt_t  owed_q [`EFPGA_N_PORTS];

  assign drop = fab_valid_i & ~port_en_i;

  always_comb begin
    for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
      owed_nz[p]  = owed_q[p] != '0;
      owed_out[p] = owed_nz[p] & ~buf_credit_i[p];  // buffer credit wins the slot
    end
  end

  assign fab_credit_o = buf_credit_i | owed_nz;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid_o <= '0;
      for (int p = 0; p < `EFPGA_N_PORTS; p++) owed_q[p] <= '0;
    end else begin
      buf_valid_o <= fab_valid_i & port_en_i;
      for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
        owed_q[p] <= owed_q[p] + owed_cnt_t'(drop[p]) - owed_cnt_t'(owed_out[p]);
      end
    end
  end

  // request payload, l2 window prepended
  always_ff @(posedge asic_clk_i) begin
    for (int p = 0; p < `EFPGA_N_PORTS; p++) begin
      if (fab_valid_i[p] && port_en_i[p]) begin
        buf_req_o[p].wen   <= fab_req_i[p].wen;
        buf_req_o[p].addr  <= {`EFPGA_L2_BASE, fab_req_i[p].offset};
        buf_req_o[p].be    <= fab_req_i[p].be;
        buf_req_o[p].wdata <= fab_req_i[p].wdata;
      end
    end
  end

endmodule

//--- verilog/sideband_pkg.sv
// types for control word, event vector and port selection
`include "efpga_macros.svh"

package sideband_pkg;

  typedef logic [`EFPGA_CTRL_W-1:0] ctrl_word_t;

  typedef logic [`EFPGA_N_EVENTS-1:0] event_vec_t;  // one bit per event line

  // index of a fabric port
  typedef logic [$clog2(`EFPGA_N_PORTS)-1:0] port_idx_t;

  typedef logic [`EFPGA_N_PORTS-1:0] port_mask_t;  // one bit per port

endpackage

//--- verilog/tcdm_pkg.sv
// bus vector types
// request structs of the fabric side and the l2 side
`include "efpga_macros.svh"

package tcdm_pkg;

  typedef logic [`EFPGA_OFF_W-1:0]  addr_off_t;  // fabric offset
  typedef logic [`EFPGA_ADDR_W-1:0] l2_addr_t;   // base window plus offset
  typedef logic [`EFPGA_DATA_W-1:0] data_t;
  typedef logic [`EFPGA_BE_W-1:0]   be_t;

  // request as issued by a fabric port
  typedef struct packed {
    logic      wen;     // high for read
    addr_off_t offset;
    be_t       be;
    data_t     wdata;
  } fab_req_t;

  // request as presented on the l2 bus
  typedef struct packed {
    logic     wen;      // high for read
    l2_addr_t addr;
    be_t      be;
    data_t    wdata;
  } l2_req_t;

endpackage

//--- verilog/efpga_macros.svh
// sizes and constants shared by the efpga tcdm bridge
`ifndef EFPGA_MACROS_SVH
`define EFPGA_MACROS_SVH

`define EFPGA_N_PORTS   4        // fabric tcdm ports
`define EFPGA_N_EVENTS  16       // fabric event lines
`define EFPGA_OFF_W     20       // fabric address offset
`define EFPGA_ADDR_W    32       // full l2 address
`define EFPGA_DATA_W    32
`define EFPGA_BE_W      4

`define EFPGA_L2_BASE   12'h1C0  // upper bits of the l2 window

`define EFPGA_BUF_DEPTH 4        // entries per port, also initial credits
`define EFPGA_TAG_DEPTH 8        // outstanding l2 requests

`define EFPGA_CTRL_W    32       // sideband control word

`endif
